// File: i2c_defines.svh
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// ------------------------------------------------------------
// bus timing
// ------------------------------------------------------------
`define I2C_SCL_DIV      100  // system clocks per scl period

// ------------------------------------------------------------
// widths and flow control
// ------------------------------------------------------------
`define I2C_DATA_W       8    // data and byte address
`define I2C_DEV_W        7    // 7-bit device address
`define I2C_REG_ADDR_W   2    // config register select
`define I2C_BIT_CNT_W    4    // counts 0..8
`define I2C_CMD_CREDITS  1    // host credits after reset

`endif

// File: i2c_pkg.sv
`default_nettype none

`include "i2c_defines.svh"

package i2c_pkg;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } i2c_op_e;

    typedef logic [`I2C_DATA_W-1:0] i2c_data_t;
    typedef logic [`I2C_DEV_W-1:0]  i2c_dev_t;

    // one-clock quarter markers from the scl generator
    typedef enum logic [2:0] {
        ph_none,
        ph_rise,
        ph_high_mid,    // sample point
        ph_fall,
        ph_low_mid      // sda change point
    } scl_phase_e;

    typedef struct packed {
        i2c_dev_t dev;
        logic     rw;   // 1 = read
    } i2c_addr_byte_s;

    typedef union packed {
        i2c_data_t      raw;
        i2c_addr_byte_s addr;
    } i2c_byte_u;

    typedef enum logic [`I2C_REG_ADDR_W-1:0] {
        sel_dev   = 2'd0,
        sel_addr  = 2'd1,
        sel_wdata = 2'd2
    } reg_sel_e;

endpackage

`default_nettype wire

// File: i2c_if.sv
`timescale 1ns/1ps
`default_nettype none

// command slot from the intake to the byte engine
interface cmd_if;
    logic               valid;
    i2c_pkg::i2c_op_e   op;
    i2c_pkg::i2c_dev_t  dev;
    i2c_pkg::i2c_data_t byte_addr;
    i2c_pkg::i2c_data_t wdata;
    logic               take;       // one-clock pulse when engine leaves idle

    modport intake (
        output valid, op, dev, byte_addr, wdata,
        input  take
    );

    modport engine (
        input  valid, op, dev, byte_addr, wdata,
        output take
    );
endinterface

// transfer result from the byte engine to the output side
interface rsp_if;
    logic               valid;      // pulses when stop is complete
    i2c_pkg::i2c_op_e   op;
    i2c_pkg::i2c_data_t rdata;
    logic               nack;

    modport engine (
        output valid, op, rdata, nack
    );

    modport out (
        input  valid, op, rdata, nack
    );
endinterface

`default_nettype wire

// File: i2c_cmd_intake.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_intake (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_wr,
    input  i2c_pkg::reg_sel_e  reg_addr,
    input  i2c_pkg::i2c_data_t reg_data,
    input  logic               cmd_valid,
    input  i2c_pkg::i2c_op_e   cmd_op,
    cmd_if.intake              cmd
);

    i2c_pkg::i2c_dev_t  dev_q;
    i2c_pkg::i2c_data_t byte_addr_q;
    i2c_pkg::i2c_data_t wdata_q;

    // ------------------------------------------------------------
    // host configuration registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dev_q       <= '0;
            byte_addr_q <= '0;
            wdata_q     <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                i2c_pkg::sel_dev:   dev_q       <= i2c_pkg::i2c_dev_t'(reg_data); // low 7 bits
                i2c_pkg::sel_addr:  byte_addr_q <= reg_data;
                i2c_pkg::sel_wdata: wdata_q     <= reg_data;
                default: ;                                 // select 3 unused
            endcase
        end
    end

    // ------------------------------------------------------------
    // one-entry command slot
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.valid <= 1'b0;
        end else if (cmd_valid) begin
            cmd.valid <= 1'b1;
        end else if (cmd.take) begin
            cmd.valid <= 1'b0;                             // engine has it
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cmd.op        <= cmd_op;                       // snapshot, later reg writes ignored
            cmd.dev       <= dev_q;
            cmd.byte_addr <= byte_addr_q;
            cmd.wdata     <= wdata_q;
        end
    end

endmodule

`default_nettype wire

// File: i2c_scl_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_scl_gen (
    input  logic                clk,
    input  logic                rst_n,
    output logic                scl,
    output i2c_pkg::scl_phase_e phase
);

    localparam int cnt_w = $clog2(`I2C_SCL_DIV);

    // compare points, markers show up one clock later
    localparam logic [cnt_w-1:0] at_rise     = cnt_w'(`I2C_SCL_DIV - 1);
    localparam logic [cnt_w-1:0] at_high_mid = cnt_w'(`I2C_SCL_DIV / 4 - 1);
    localparam logic [cnt_w-1:0] at_fall     = cnt_w'(`I2C_SCL_DIV / 2 - 1);
    localparam logic [cnt_w-1:0] at_low_mid  = cnt_w'(`I2C_SCL_DIV * 3 / 4 - 1);

    logic [cnt_w-1:0] div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            scl     <= 1'b0;
            phase   <= i2c_pkg::ph_none;
        end else begin
            div_cnt <= (div_cnt == at_rise) ? '0 : div_cnt + 1'b1;
            if (div_cnt == at_rise) begin
                scl   <= 1'b1;                            // wrap, scl rises
                phase <= i2c_pkg::ph_rise;
            end else if (div_cnt == at_high_mid) begin
                phase <= i2c_pkg::ph_high_mid;
            end else if (div_cnt == at_fall) begin
                scl   <= 1'b0;                            // half period
                phase <= i2c_pkg::ph_fall;
            end else if (div_cnt == at_low_mid) begin
                phase <= i2c_pkg::ph_low_mid;
            end else begin
                phase <= i2c_pkg::ph_none;
            end
        end
    end

endmodule

`default_nettype wire

// File: i2c_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_byte_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  i2c_pkg::scl_phase_e phase,
    input  logic                sda_in,
    output logic                sda_drive_low,
    cmd_if.engine               cmd,
    rsp_if.engine               rsp
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_send,
        st_ack,         // slave acknowledge
        st_restart,
        st_recv,
        st_mnack,       // master nack after the read byte
        st_stop
    } state_e;

    localparam logic [`I2C_BIT_CNT_W-1:0] last_bit = `I2C_DATA_W;

    state_e                    state;
    i2c_pkg::i2c_byte_u        shreg;
    logic [`I2C_BIT_CNT_W-1:0] bit_cnt;
    logic [1:0]                byte_idx;
    logic                      is_low_mid;
    logic                      is_high_mid;
    logic                      is_fall;
    logic                      byte_done;

    assign is_low_mid  = (phase == i2c_pkg::ph_low_mid);
    assign is_high_mid = (phase == i2c_pkg::ph_high_mid);
    assign is_fall     = (phase == i2c_pkg::ph_fall);
    assign byte_done   = (bit_cnt == last_bit);

    assign cmd.take  = (state == st_idle) && cmd.valid;
    assign rsp.rdata = shreg.raw;                          // holds the read byte at stop

    // ------------------------------------------------------------
    // transaction FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            shreg.raw     <= '0;
            sda_drive_low <= 1'b0;                         // sda released
            bit_cnt       <= '0;
            byte_idx      <= '0;
            rsp.valid     <= 1'b0;
            rsp.op        <= i2c_pkg::op_write;
            rsp.nack      <= 1'b0;
        end else begin
            rsp.valid <= 1'b0;
            case (state)
                st_idle: begin
                    sda_drive_low <= 1'b0;
                    if (cmd.valid) begin
                        shreg.addr.dev <= cmd.dev;
                        shreg.addr.rw  <= 1'b0;            // first byte is always a write
                        rsp.op         <= cmd.op;
                        rsp.nack       <= 1'b0;
                        bit_cnt        <= '0;
                        byte_idx       <= '0;
                        state          <= st_start;
                    end
                end
                st_start: begin
                    if (is_high_mid) begin
                        sda_drive_low <= 1'b1;             // sda falls while scl high
                    end else if (is_fall && sda_drive_low) begin
                        state <= st_send;
                    end
                end
                st_send: begin
                    if (is_low_mid && !byte_done) begin
                        sda_drive_low <= ~shreg.raw[`I2C_DATA_W-1]; // msb first
                        shreg.raw     <= {shreg.raw[`I2C_DATA_W-2:0], 1'b0};
                        bit_cnt       <= bit_cnt + 1'b1;
                    end else if (is_fall && byte_done) begin
                        bit_cnt <= '0;
                        state   <= st_ack;
                    end
                end
                st_ack: begin
                    if (is_low_mid) begin
                        sda_drive_low <= 1'b0;             // let the slave drive
                    end else if (is_high_mid) begin
                        rsp.nack <= sda_in;                // high means no ack
                    end else if (is_fall) begin
                        if (rsp.nack) begin
                            state <= st_stop;              // abort
                        end else begin
                            case (byte_idx)
                                2'd0: begin
                                    shreg.raw <= cmd.byte_addr;
                                    byte_idx  <= 2'd1;
                                    state     <= st_send;
                                end
                                2'd1: begin
                                    if (rsp.op == i2c_pkg::op_write) begin
                                        shreg.raw <= cmd.wdata;
                                        byte_idx  <= 2'd2;
                                        state     <= st_send;
                                    end else begin
                                        state <= st_restart;
                                    end
                                end
                                default: begin
                                    state <= (rsp.op == i2c_pkg::op_write) ? st_stop : st_recv;
                                end
                            endcase
                        end
                    end
                end
                st_restart: begin
                    if (is_high_mid) begin
                        sda_drive_low <= 1'b1;             // repeated start
                    end else if (is_fall && sda_drive_low) begin
                        shreg.addr.dev <= cmd.dev;
                        shreg.addr.rw  <= 1'b1;
                        byte_idx       <= 2'd2;
                        state          <= st_send;
                    end
                end
                st_recv: begin
                    if (is_low_mid) begin
                        sda_drive_low <= 1'b0;
                    end else if (is_high_mid) begin
                        shreg.raw <= {shreg.raw[`I2C_DATA_W-2:0], sda_in};
                        bit_cnt   <= bit_cnt + 1'b1;
                    end else if (is_fall && byte_done) begin
                        bit_cnt <= '0;
                        state   <= st_mnack;
                    end
                end
                st_mnack: begin
                    if (is_fall) begin
                        state <= st_stop;                  // sda left high, that is the nack
                    end
                end
                st_stop: begin
                    if (is_low_mid) begin
                        sda_drive_low <= 1'b1;
                    end else if (is_high_mid && sda_drive_low) begin
                        sda_drive_low <= 1'b0;             // sda rises while scl high
                        rsp.valid     <= 1'b1;
                        state         <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: i2c_rsp_out.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_rsp_out (
    input  logic               clk,
    input  logic               rst_n,
    rsp_if.out                 rsp,
    output logic               rsp_valid,
    output i2c_pkg::i2c_data_t rsp_data,
    output logic               rsp_nack,
    output logic               cmd_credit
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid  <= 1'b0;
            cmd_credit <= 1'b0;
            rsp_nack   <= 1'b0;
        end else begin
            rsp_valid  <= rsp.valid;
            cmd_credit <= rsp.valid;                       // one credit back per response
            if (rsp.valid) begin
                rsp_nack <= rsp.nack;
            end
        end
    end

    // write responses leave the last read byte in place
    always_ff @(posedge clk) begin
        if (rsp.valid && rsp.op == i2c_pkg::op_read) begin
            rsp_data <= rsp.rdata;
        end
    end

endmodule

`default_nettype wire

// File: i2c_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_wr,
    input  i2c_pkg::reg_sel_e  reg_addr,
    input  i2c_pkg::i2c_data_t reg_data,
    input  logic               cmd_valid,
    input  i2c_pkg::i2c_op_e   cmd_op,
    output logic               cmd_credit,
    output logic               scl,
    inout  wire                sda,
    output logic               rsp_valid,
    output i2c_pkg::i2c_data_t rsp_data,
    output logic               rsp_nack
);

    i2c_pkg::scl_phase_e phase;
    logic                sda_drive_low;
    logic                sda_in;

    cmd_if cmd_bus ();
    rsp_if rsp_bus ();

    // ------------------------------------------------------------
    // instances
    // ------------------------------------------------------------
    i2c_cmd_intake i2c_cmd_intake_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd       (cmd_bus.intake)
    );

    i2c_scl_gen i2c_scl_gen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .scl   (scl),
        .phase (phase)
    );

    i2c_byte_engine i2c_byte_engine_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase         (phase),
        .sda_in        (sda_in),
        .sda_drive_low (sda_drive_low),
        .cmd           (cmd_bus.engine),
        .rsp           (rsp_bus.engine)
    );

    i2c_rsp_out i2c_rsp_out_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsp        (rsp_bus.out),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_nack   (rsp_nack),
        .cmd_credit (cmd_credit)
    );

    // open-drain pad, never driven high
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                 // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;                       // released just after the third edge
    end

endmodule

`default_nettype wire

// File: tb_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_model (
    input  wire  scl,
    inout  wire  sda,
    output logic bus_err
);

    localparam logic [6:0] dev_addr = 7'h50;

    logic [7:0] mem [0:255];
    logic [7:0] shift;
    logic [7:0] tx;
    logic [7:0] ptr;                           // word pointer, no auto-increment
    logic [3:0] cnt;                           // scl rising edges in this byte slot
    logic [1:0] byte_num;
    logic       active;
    logic       addressed;
    logic       rd_mode;
    logic       drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'ha5;
        end
        bus_err   = 1'b0;
        shift     = '0;
        tx        = '0;
        ptr       = '0;
        cnt       = '0;
        byte_num  = '0;
        active    = 1'b0;
        addressed = 1'b0;
        rd_mode   = 1'b0;
        drive_low = 1'b0;
    end

    // ------------------------------------------------------------
    // start, stop and bus legality
    // ------------------------------------------------------------
    always @(sda) begin
        if (scl === 1'b1 && (sda === 1'b0 || sda === 1'b1)) begin
            if (active && cnt != 4'd1) begin
                bus_err = 1'b1;                // sda moved inside a byte slot
            end else if (sda === 1'b0) begin
                active    = 1'b1;              // start or repeated start
                cnt       = '0;
                byte_num  = '0;
                addressed = 1'b0;
                rd_mode   = 1'b0;
            end else begin
                active    = 1'b0;              // stop
                addressed = 1'b0;
                rd_mode   = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // bit level
    // ------------------------------------------------------------
    always @(posedge scl) begin
        if (active) begin
            if (cnt < 4'd8 && !rd_mode) begin
                shift = {shift[6:0], (sda !== 1'b0)};
            end
            cnt = cnt + 1'b1;
        end
    end

    always @(negedge scl) begin
        if (active) begin
            if (cnt == 4'd8) begin
                if (rd_mode) begin
                    drive_low = 1'b0;          // master ack slot
                end else begin
                    case (byte_num)
                        2'd0:    addressed = (shift[7:1] == dev_addr);
                        2'd1:    if (addressed) ptr = shift;
                        default: if (addressed) mem[ptr] = shift;
                    endcase
                    drive_low = addressed;     // ack
                end
            end else if (cnt == 4'd9) begin
                cnt       = '0;
                drive_low = 1'b0;
                if (rd_mode) begin
                    rd_mode   = 1'b0;          // single byte read is over
                    addressed = 1'b0;
                end else if (addressed && byte_num == 2'd0 && shift[0]) begin
                    rd_mode   = 1'b1;
                    tx        = mem[ptr];
                    drive_low = !tx[7];        // msb right after the ack
                end
                byte_num = byte_num + 1'b1;
            end else if (rd_mode && cnt >= 4'd1 && cnt <= 4'd7) begin
                drive_low = !tx[7 - cnt];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module tb_i2c_master;

    localparam int                n_cmds     = 24;
    localparam int                max_cycles = n_cmds * 45 * `I2C_SCL_DIV;
    localparam i2c_pkg::i2c_dev_t eeprom_dev = 7'h50;

    logic               clk;
    logic               rst_n;
    logic               reg_wr;
    i2c_pkg::reg_sel_e  reg_addr;
    i2c_pkg::i2c_data_t reg_data;
    logic               cmd_valid;
    i2c_pkg::i2c_op_e   cmd_op;
    logic               cmd_credit;
    logic               scl;
    wire                sda;
    logic               rsp_valid;
    i2c_pkg::i2c_data_t rsp_data;
    logic               rsp_nack;
    logic               bus_err;

    i2c_pkg::i2c_data_t shadow [0:255];        // reference memory
    logic [15:0]        lfsr          = 16'd96;
    int                 credits       = `I2C_CMD_CREDITS;
    int                 credit_pulses = 0;
    int                 rsp_pulses    = 0;
    int                 cycles        = 0;
    logic               scl_prev      = 1'b0;
    int                 scl_clks      = 0;
    int                 scl_rises     = 0;

    tb_clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    i2c_master_top i2c_master_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_credit (cmd_credit),
        .scl        (scl),
        .sda        (sda),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_nack   (rsp_nack)
    );

    tb_eeprom_model eeprom_inst (
        .scl     (scl),
        .sda     (sda),
        .bus_err (bus_err)
    );

    pullup sda_pullup (sda);                   // bus pull-up

    // ------------------------------------------------------------
    // random source and checks
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic draw(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input i2c_pkg::i2c_data_t got,
                              input i2c_pkg::i2c_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_nack(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // host side
    // ------------------------------------------------------------
    task automatic write_reg(input i2c_pkg::reg_sel_e sel, input i2c_pkg::i2c_data_t val);
        @(posedge clk);
        #1;
        reg_wr   = 1'b1;
        reg_addr = sel;
        reg_data = val;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic issue(input i2c_pkg::i2c_op_e op);
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd_op    = op;
        credits   = credits - 1;               // spent on issue
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_response();
        @(negedge clk);
        while (rsp_valid !== 1'b1) begin
            @(negedge clk);
        end
        check_flag("cmd_credit", cmd_credit, 1'b1);  // credit rides with the response
    endtask

    // credits come back only through cmd_credit
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (cmd_credit === 1'b1) begin
                credit_pulses = credit_pulses + 1;
                credits       = credits + 1;
                if (credits > `I2C_CMD_CREDITS) begin
                    abort_run("cmd_credit returned a credit with no command outstanding");
                end
            end
            if (rsp_valid === 1'b1) begin
                rsp_pulses = rsp_pulses + 1;
            end
        end
    end

    // scl period and high time in system clocks
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (scl === 1'b1 && scl_prev === 1'b0) begin
                if (scl_rises > 0) begin
                    check_count("scl period", scl_clks, `I2C_SCL_DIV);
                end
                scl_rises = scl_rises + 1;
                scl_clks  = 0;
            end else if (scl === 1'b0 && scl_prev === 1'b1 && scl_rises > 0) begin
                check_count("scl high time", scl_clks, `I2C_SCL_DIV / 2);
            end
            scl_clks = scl_clks + 1;
            scl_prev = scl;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            abort_run("timeout: the commands did not finish within the cycle limit");
        end else if (bus_err === 1'b1) begin
            abort_run("bus error: SDA changed while SCL was high inside a byte");
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        i2c_pkg::i2c_op_e   op;
        i2c_pkg::i2c_data_t pick;
        i2c_pkg::i2c_data_t addr;
        i2c_pkg::i2c_data_t wdata;
        i2c_pkg::i2c_dev_t  dev;
        i2c_pkg::i2c_data_t last_rdata;
        logic               have_read;
        logic               exp_nack;

        reg_wr     = 1'b0;
        reg_addr   = i2c_pkg::sel_dev;
        reg_data   = '0;
        cmd_valid  = 1'b0;
        cmd_op     = i2c_pkg::op_write;
        have_read  = 1'b0;
        last_rdata = '0;
        for (int a = 0; a < 256; a++) begin
            shadow[a] = 8'(a) ^ 8'ha5;
        end

        wait (rst_n === 1'b1);
        repeat (8) begin                       // idle bus after reset
            @(negedge clk);
            check_flag("rsp_valid", rsp_valid, 1'b0);
            check_flag("cmd_credit", cmd_credit, 1'b0);
            check_flag("sda", sda, 1'b1);
        end

        for (int n = 0; n < n_cmds; n++) begin
            draw(1, pick);
            op = i2c_pkg::i2c_op_e'(pick[0]);
            draw(3, pick);
            addr = {pick[2:0], 5'h0b};         // 8 addresses so reads hit writes
            draw(8, wdata);
            draw(3, pick);
            if (pick[2:0] != 3'd0) begin
                dev = eeprom_dev;
            end else begin
                draw(7, pick);
                dev = pick[6:0];
                if (dev == eeprom_dev) begin
                    dev = dev ^ 7'h01;
                end
            end

            while (credits == 0) begin
                @(negedge clk);
            end
            write_reg(i2c_pkg::sel_dev, {1'b0, dev});
            write_reg(i2c_pkg::sel_addr, addr);
            write_reg(i2c_pkg::sel_wdata, wdata);
            issue(op);
            write_reg(i2c_pkg::sel_wdata, ~wdata);    // must not reach the bus
            wait_response();

            exp_nack = (dev != eeprom_dev);
            check_nack("rsp_nack", rsp_nack, exp_nack);
            if (op == i2c_pkg::op_write) begin
                if (!exp_nack) begin
                    shadow[addr] = wdata;
                end
                if (have_read) begin
                    check_data("rsp_data", rsp_data, last_rdata);
                end
            end else if (!exp_nack) begin
                check_data("rsp_data", rsp_data, shadow[addr]);
                last_rdata = shadow[addr];
                have_read  = 1'b1;
            end else begin
                have_read = 1'b0;              // aborted read leaves data undefined
            end
        end

        repeat (4) @(negedge clk);
        for (int a = 0; a < 256; a++) begin
            check_data($sformatf("eeprom mem[%02h]", a), eeprom_inst.mem[a], shadow[a]);
        end
        if (credit_pulses != n_cmds || rsp_pulses != n_cmds) begin
            abort_run($sformatf("saw %0d credit pulses and %0d responses for %0d commands",
                                credit_pulses, rsp_pulses, n_cmds));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
i2c_pkg.sv
i2c_if.sv
i2c_cmd_intake.sv
i2c_scl_gen.sv
i2c_byte_engine.sv
i2c_rsp_out.sv
i2c_master_top.sv
tb_clk_gen.sv
tb_eeprom_model.sv
tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_eeprom_master

sources:
  - include_dirs:
      - .
    files:
      - i2c_pkg.sv
      - i2c_if.sv
      - i2c_cmd_intake.sv
      - i2c_scl_gen.sv
      - i2c_byte_engine.sv
      - i2c_rsp_out.sv
      - i2c_master_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_eeprom_model.sv
      - tb_i2c_master.sv
